//--- div_config_pkg.sv
// Divide unit sizes: operand width, queue depth, iteration count and counter widths
`default_nettype none

package div_config_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath width
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen = 32;

    // Request queue
    localparam int div_fifo_depth = 2;
    localparam int div_fifo_ptr_w = 1;
    localparam int div_fifo_cnt_w = 2;
    // Last slot index, pointers wrap after it
    localparam logic [div_fifo_ptr_w-1:0] div_fifo_last = div_fifo_ptr_w'(div_fifo_depth - 1);
    // Occupancy at which the queue stops accepting
    localparam logic [div_fifo_cnt_w-1:0] div_fifo_full_cnt = div_fifo_cnt_w'(div_fifo_depth);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Iterative divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One quotient bit per step
    localparam int div_iterations = xlen;
    localparam int div_count_w = 6;
    // Counter load value, counts down to zero on the final step
    localparam logic [div_count_w-1:0] div_count_init = div_count_w'(div_iterations - 1);

endpackage

`default_nettype wire

//--- div_control.sv
// Module div_control: divide sequencing FSM and writeback done register
`default_nettype none

module div_control (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic q_valid,
    input  wire logic divisor_zero,
    input  wire logic cnt_last,
    input  wire logic accepted,
    output logic      load,
    output logic      step,
    output logic      cnt_load,
    output logic      cnt_step,
    output logic      capture,
    output logic      q_pop,
    output logic      done_next_cycle
);

    div_types_pkg::div_state_t state;
    div_types_pkg::div_state_t state_next;
    logic                      output_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Free when empty, or when the held result leaves this cycle
    assign output_ready = ~done_next_cycle | (done_next_cycle & accepted);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        load       = 1'b0;
        step       = 1'b0;
        cnt_load   = 1'b0;
        cnt_step   = 1'b0;
        capture    = 1'b0;
        q_pop      = 1'b0;
        case (state)
            div_types_pkg::st_idle: begin
                if (q_valid) begin
                    if (divisor_zero) begin
                        // Zero divisor bypasses the divider entirely
                        capture = output_ready;
                        q_pop   = output_ready;
                    end else begin
                        load       = 1'b1;
                        cnt_load   = 1'b1;
                        state_next = div_types_pkg::st_run;
                    end
                end
            end
            div_types_pkg::st_run: begin
                step     = 1'b1;
                cnt_step = 1'b1;
                // Final shift-subtract this cycle
                if (cnt_last) begin
                    state_next = div_types_pkg::st_finish;
                end
            end
            div_types_pkg::st_finish: begin
                // Hold quotient and remainder until writeback has room
                if (output_ready) begin
                    capture    = 1'b1;
                    q_pop      = 1'b1;
                    state_next = div_types_pkg::st_idle;
                end
            end
            default: state_next = div_types_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_types_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Set by a capture, cleared by writeback accepting
    always_ff @(posedge clk) begin
        if (rst) begin
            done_next_cycle <= 1'b0;
        end else if (capture) begin
            done_next_cycle <= 1'b1;
        end else if (accepted) begin
            done_next_cycle <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- div_datapath.sv
// Module div_datapath: operand magnitudes, restoring divider, sign correction, result register
`default_nettype none

module div_datapath (
    input  wire logic                            clk,
    input  wire logic [div_config_pkg::xlen-1:0] rs1,
    input  wire logic [div_config_pkg::xlen-1:0] rs2,
    input  div_types_pkg::div_op_t               op,
    input  wire logic                            load,
    input  wire logic                            step,
    input  wire logic                            capture,
    output logic                                 divisor_zero,
    output logic [div_config_pkg::xlen-1:0]      rd
);

    localparam int w = div_config_pkg::xlen;

    // Sign decode
    logic         signed_op;
    logic         dividend_neg;
    logic         divisor_neg;
    logic         quotient_neg;
    logic         remainder_neg;

    // Magnitudes
    logic [w-1:0] mag_a;
    logic [w-1:0] mag_b;

    // Divider registers, the dividend register fills with quotient bits
    logic [w-1:0] dividend_q;
    logic [w-1:0] divisor_q;
    logic [w-1:0] remainder_q;

    // Trial subtraction, one extra bit for the borrow
    logic [w:0]   shifted;
    logic [w:0]   diff;

    logic [w-1:0] result_raw;
    logic         negate;
    logic [w-1:0] result_signed;
    logic [w-1:0] result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand conditioning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DIV and REM are the signed ops
    assign signed_op     = ~op[0];
    assign dividend_neg  = signed_op & rs1[w-1];
    assign divisor_neg   = signed_op & rs2[w-1];
    assign quotient_neg  = signed_op & (rs1[w-1] ^ rs2[w-1]);
    // Remainder takes the dividend's sign
    assign remainder_neg = dividend_neg;

    assign mag_a = dividend_neg ? (~rs1 + 1'b1) : rs1;
    assign mag_b = divisor_neg ? (~rs2 + 1'b1) : rs2;

    assign divisor_zero = (mag_b == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Restoring divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bring down the next dividend bit
    assign shifted = {remainder_q, dividend_q[w-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (load) begin
            dividend_q  <= mag_a;
            divisor_q   <= mag_b;
            remainder_q <= '0;
        end else if (step) begin
            // No borrow: keep the difference, quotient bit is one
            remainder_q <= diff[w] ? shifted[w-1:0] : diff[w-1:0];
            dividend_q  <= {dividend_q[w-2:0], ~diff[w]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sign correction and result select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign result_raw    = op[1] ? remainder_q : dividend_q;
    assign negate        = op[1] ? remainder_neg : quotient_neg;
    assign result_signed = negate ? (~result_raw + 1'b1) : result_raw;

    // Divide by zero: all ones for quotient, dividend for remainder
    // Most negative over minus one wraps back to most negative here
    assign result = divisor_zero ? (op[1] ? rs1 : '1) : result_signed;

    // Written only on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            rd <= result;
        end
    end

endmodule

`default_nettype wire

//--- div_input_fifo.sv
// Module div_input_fifo: in-order request queue of operands and opcode
`default_nettype none

module div_input_fifo (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   push,
    input  wire logic                                   pop,
    input  wire logic [div_config_pkg::xlen-1:0]        in_rs1,
    input  wire logic [div_config_pkg::xlen-1:0]        in_rs2,
    input  div_types_pkg::div_op_t                      in_op,
    output logic                                        valid,
    output logic                                        full,
    output logic [div_config_pkg::xlen-1:0]             out_rs1,
    output logic [div_config_pkg::xlen-1:0]             out_rs2,
    output div_types_pkg::div_op_t                      out_op
);

    // Entry storage
    logic [div_config_pkg::xlen-1:0] rs1_mem [div_config_pkg::div_fifo_depth];
    logic [div_config_pkg::xlen-1:0] rs2_mem [div_config_pkg::div_fifo_depth];
    div_types_pkg::div_op_t          op_mem  [div_config_pkg::div_fifo_depth];

    logic [div_config_pkg::div_fifo_ptr_w-1:0] wr_ptr;
    logic [div_config_pkg::div_fifo_ptr_w-1:0] rd_ptr;
    logic [div_config_pkg::div_fifo_cnt_w-1:0] count;
    logic                                      push_ok;

    // Push dropped when full, ready is low then anyway
    assign push_ok = push & ~full;

    // Write side, no reset on payload
    always_ff @(posedge clk) begin
        if (push_ok) begin
            rs1_mem[wr_ptr] <= in_rs1;
            rs2_mem[wr_ptr] <= in_rs2;
            op_mem[wr_ptr]  <= in_op;
        end
    end

    // Pointers wrap at the last slot, count tracks occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == div_config_pkg::div_fifo_last) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == div_config_pkg::div_fifo_last) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry shown combinationally
    assign valid   = (count != '0);
    assign full    = (count == div_config_pkg::div_fifo_full_cnt);
    assign out_rs1 = rs1_mem[rd_ptr];
    assign out_rs2 = rs2_mem[rd_ptr];
    assign out_op  = op_mem[rd_ptr];

endmodule

`default_nettype wire

//--- div_iter_counter.sv
// Module div_iter_counter: down-counter of remaining divide steps with last-step flag
`default_nettype none

module div_iter_counter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load,
    input  wire logic step,
    output logic      last
);

    // Steps remaining after the current one
    logic [div_config_pkg::div_count_w-1:0] count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Count register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= div_config_pkg::div_count_init;
        end else if (step && !last) begin
            count <= count - 1'b1;
        end
        // Otherwise hold, and stay at zero after the final step
    end

    // Zero means this step is the final one
    assign last = (count == '0);

endmodule

`default_nettype wire

//--- div_types_pkg.sv
// Divide unit enums: request opcodes and controller states
`default_nettype none

package div_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit 0 set: unsigned operation
    // Bit 1 set: remainder selected instead of quotient
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Waiting on a queued request
    // Shift-subtract in progress
    // Result ready, waiting on the writeback slot
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_run    = 2'd1,
        st_finish = 2'd2
    } div_state_t;

endpackage

`default_nettype wire

//--- div_unit.f
div_config_pkg.sv
div_types_pkg.sv
div_input_fifo.sv
div_iter_counter.sv
div_control.sv
div_datapath.sv
div_unit.sv
div_unit_chk.sv
div_unit_tb.sv

//--- div_unit.sv
// Module div_unit: divide unit top with request queue, controller, step counter and datapath
`default_nettype none

module div_unit (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            new_request,
    output logic                                 ready,
    input  wire logic [div_config_pkg::xlen-1:0] rs1,
    input  wire logic [div_config_pkg::xlen-1:0] rs2,
    input  div_types_pkg::div_op_t               op,
    output logic                                 done_next_cycle,
    input  wire logic                            accepted,
    output logic [div_config_pkg::xlen-1:0]      rd
);

    // Queue head
    logic                              q_valid;
    logic                              q_full;
    logic                              q_pop;
    logic [div_config_pkg::xlen-1:0]   q_rs1;
    logic [div_config_pkg::xlen-1:0]   q_rs2;
    div_types_pkg::div_op_t            q_op;

    // Controller strobes
    logic load;
    logic step;
    logic capture;
    logic cnt_load;
    logic cnt_step;
    logic cnt_last;
    logic divisor_zero;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_input_fifo u_input_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (new_request),
        .pop     (q_pop),
        .in_rs1  (rs1),
        .in_rs2  (rs2),
        .in_op   (op),
        .valid   (q_valid),
        .full    (q_full),
        .out_rs1 (q_rs1),
        .out_rs2 (q_rs2),
        .out_op  (q_op)
    );

    // Accept whenever a slot is free
    assign ready = ~q_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing and step count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    div_control u_control (
        .clk             (clk),
        .rst             (rst),
        .q_valid         (q_valid),
        .divisor_zero    (divisor_zero),
        .cnt_last        (cnt_last),
        .accepted        (accepted),
        .load            (load),
        .step            (step),
        .cnt_load        (cnt_load),
        .cnt_step        (cnt_step),
        .capture         (capture),
        .q_pop           (q_pop),
        .done_next_cycle (done_next_cycle)
    );

    div_iter_counter u_iter_counter (
        .clk  (clk),
        .rst  (rst),
        .load (cnt_load),
        .step (cnt_step),
        .last (cnt_last)
    );

    // Datapath works on the queue head until it is popped
    div_datapath u_datapath (
        .clk          (clk),
        .rs1          (q_rs1),
        .rs2          (q_rs2),
        .op           (q_op),
        .load         (load),
        .step         (step),
        .capture      (capture),
        .divisor_zero (divisor_zero),
        .rd           (rd)
    );

endmodule

`default_nettype wire

//--- div_unit_cases.txt
// Columns are opcode, rs1, rs2 and expected rd, all hex
// Opcode 0 div, 1 divu, 2 rem, 3 remu
0 00000014 00000003 00000006
2 ffffffec 00000003 fffffffe
0 ffffffec 00000003 fffffffa
0 00000014 fffffffd fffffffa
2 00000014 fffffffd 00000002
0 ffffffec fffffffd 00000006
2 ffffffec fffffffd fffffffe
1 ffffffec 00000003 5555554e
3 ffffffec 00000003 00000002
1 00000064 00000007 0000000e
0 12345678 00000000 ffffffff
1 12345678 00000000 ffffffff
2 12345678 00000000 12345678
3 87654321 00000000 87654321
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000
3 80000000 ffffffff 80000000
1 deadbeef 00001000 000deadb
3 deadbeef 00001000 00000eef
2 fffffff9 00000002 ffffffff

//--- div_unit_chk.sv
// Module div_unit_chk: concurrent assertions on request, hold and FSM rules, bound to div_unit
`default_nettype none

module div_unit_chk (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            new_request,
    input  wire logic                            ready,
    input  wire logic                            done_next_cycle,
    input  wire logic                            accepted,
    input  wire logic [div_config_pkg::xlen-1:0] rd,
    input  wire div_types_pkg::div_state_t       state,
    input  wire logic                            step
);

    // Divider steps seen in the current run state
    int run_steps;

    always_ff @(posedge clk) begin
        if (rst || state != div_types_pkg::st_run) begin
            run_steps <= 0;
        end else if (step) begin
            run_steps <= run_steps + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) disable iff (rst) new_request |-> ready)
        else $error("new_request strobed while ready is low");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Held result must not move or vanish before accepted
    assert property (@(posedge clk) disable iff (rst)
        (done_next_cycle && !accepted) |=> (done_next_cycle && $stable(rd)))
        else $error("rd or done_next_cycle changed while waiting on accepted");

    // Nothing presented straight out of reset
    assert property (@(posedge clk) rst |=> !done_next_cycle)
        else $error("done_next_cycle high in the cycle after reset");

    // Divider steps every cycle of the run state, div_iterations in all
    assert property (@(posedge clk) disable iff (rst)
        $fell(state == div_types_pkg::st_run)
            |-> (run_steps == div_config_pkg::div_iterations))
        else $error("run state left without exactly div_iterations divider steps");

endmodule

bind div_unit div_unit_chk u_chk (
    .clk             (clk),
    .rst             (rst),
    .new_request     (new_request),
    .ready           (ready),
    .done_next_cycle (done_next_cycle),
    .accepted        (accepted),
    .rd              (rd),
    .state           (u_control.state),
    .step            (step)
);

`default_nettype wire

//--- div_unit_tb.sv
// Module div_unit_tb: clock, reset, case-file stimulus, random back-pressure and result checks
`default_nettype none

module div_unit_tb;

    localparam int num_cases   = 20;
    localparam int cycle_limit = num_cases * 40 + 200;

    logic                              clk;
    logic                              rst;
    logic                              new_request;
    logic                              ready;
    logic [div_config_pkg::xlen-1:0]   rs1;
    logic [div_config_pkg::xlen-1:0]   rs2;
    div_types_pkg::div_op_t            op;
    logic                              done_next_cycle;
    logic                              accepted;
    logic [div_config_pkg::xlen-1:0]   rd;

    // Four words per case: opcode, rs1, rs2, expected
    logic [31:0]                       case_mem [0:4*num_cases-1];
    logic [div_config_pkg::xlen-1:0]   exp_q [$];
    int                                checked = 0;
    int                                cycle_count = 0;
    logic                              saw_full = 1'b0;

    div_unit dut (
        .clk             (clk),
        .rst             (rst),
        .new_request     (new_request),
        .ready           (ready),
        .rs1             (rs1),
        .rs2             (rs2),
        .op              (op),
        .done_next_cycle (done_next_cycle),
        .accepted        (accepted),
        .rd              (rd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit from the number of cases
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_error("timeout: results did not all arrive within the cycle limit");
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_requests();
        for (int i = 0; i < num_cases; i++) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            @(posedge clk);
            while (!ready) @(posedge clk);
            new_request <= 1'b1;
            op          <= div_types_pkg::div_op_t'(case_mem[4*i][1:0]);
            rs1         <= case_mem[4*i+1];
            rs2         <= case_mem[4*i+2];
            exp_q.push_back(case_mem[4*i+3]);
            @(posedge clk);
            new_request <= 1'b0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic collect_results();
        int                              hold;
        int                              sent;
        int                              pending;
        logic                            ready_exp;
        logic [div_config_pkg::xlen-1:0] expected;
        hold = 0;
        sent = 0;
        while (checked < num_cases) begin
            @(posedge clk);
            // Queue occupancy: requests taken in, less results captured so far
            pending   = sent - checked - int'(done_next_cycle);
            ready_exp = (pending < div_config_pkg::div_fifo_depth);
            if (!ready) begin
                saw_full = 1'b1;
            end
            assert (ready === ready_exp)
                else stop_with_error($sformatf("error: time %0t ready expected %b actual %b",
                                               $time, ready_exp, ready));
            if (new_request) begin
                sent++;
            end
            if (done_next_cycle && accepted) begin
                assert (exp_q.size() > 0)
                    else stop_with_error("result presented with no request outstanding");
                expected = exp_q.pop_front();
                assert (rd === expected)
                    else stop_with_error($sformatf("error: time %0t rd expected %h actual %h",
                                                   $time, expected, rd));
                checked++;
            end
            // Accept level held for random stretches
            if (hold == 0) begin
                accepted <= ($urandom_range(0, 1) == 1);
                hold = $urandom_range(1, 6);
            end
            hold--;
        end
        accepted <= 1'b0;
    endtask

    initial begin
        new_request = 1'b0;
        accepted    = 1'b0;
        rs1         = '0;
        rs2         = '0;
        op          = div_types_pkg::op_div;
        rst         = 1'b1;
        void'($urandom(32'hbf0c));
        // Fill marks words the case file did not reach
        for (int i = 0; i < 4 * num_cases; i++) begin
            case_mem[i] = 32'ha5a5_0000 ^ i;
        end
        $readmemh("div_unit_cases.txt", case_mem);
        assert (case_mem[4*num_cases-1] != (32'ha5a5_0000 ^ (4 * num_cases - 1)))
            else stop_with_error("case file missing or shorter than expected");

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (ready === 1'b1)
            else stop_with_error($sformatf("error: time %0t ready expected 1 actual %b",
                                           $time, ready));
        assert (done_next_cycle === 1'b0)
            else stop_with_error($sformatf("error: time %0t done_next_cycle expected 0 actual %b",
                                           $time, done_next_cycle));

        fork
            drive_requests();
            collect_results();
        join

        // No extra result after the last one
        repeat (4) begin
            @(posedge clk);
            assert (done_next_cycle === 1'b0)
                else stop_with_error("extra result presented after all cases were checked");
        end
        assert (saw_full)
            else stop_with_error("ready never dropped while requests were pending");
        if (exp_q.size() == 0 && checked == num_cases) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_with_error("not every request produced exactly one result");
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f div_unit.f --top-module div_unit_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdiv_unit_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
